/* rtl/lane_fmt_pkg.sv */
package lane_fmt_pkg;

   // ----------------------------------------
   // Lane geometry toward the PHY
   // ----------------------------------------
   localparam int NUM_LANES = 7;                   // PHY lanes per user word
   localparam int LANE_BITS = 40;                  // Bits in one lane word

   // ----------------------------------------
   // Bit positions inside one lane word
   // ----------------------------------------
   localparam int PUSH_BIT  = 0;                   // Word valid toward the PHY
   localparam int STB_BIT   = 1;                   // Alignment strobe
   localparam int MRK_BIT   = 39;                  // Remote-rate word marker
   localparam int DATA_LO   = 2;                   // First payload bit

   // Payload sits between the strobe and the marker
   localparam int DATA_BITS_PER_LANE = MRK_BIT - DATA_LO;

   // ----------------------------------------
   // Lane types
   // ----------------------------------------
   typedef logic [LANE_BITS-1:0]           lane_word_t;
   typedef logic [NUM_LANES*LANE_BITS-1:0] lane_bus_t;    // Lane 0 in the low bits
   typedef logic [NUM_LANES-1:0]           lane_en_t;     // One transfer enable per lane

endpackage

/* rtl/link_cfg_pkg.sv */
package link_cfg_pkg;

   // ----------------------------------------
   // Rate codes, used as clock divisors
   // ----------------------------------------
   typedef logic [3:0] rate_t;

   localparam rate_t RATE_FULL    = 4'h1;
   localparam rate_t RATE_HALF    = 4'h2;
   localparam rate_t RATE_QUARTER = 4'h4;

   // ----------------------------------------
   // Strobe spacing
   // ----------------------------------------
   localparam int STB_INTV_BASE = 24;              // Interval seen at the remote side

   // Counted in marked words, so scaled by full over half
   localparam int STROBE_INTV = (STB_INTV_BASE * RATE_FULL) / RATE_HALF;

   // ----------------------------------------
   // User side types
   // ----------------------------------------
   typedef logic [255:0] tdata_t;                  // One streaming user word
   typedef logic [31:0]  delay_raw_t;              // Start delay as driven by software
   typedef logic [15:0]  delay_t;                  // Start delay after scaling

endpackage

/* rtl/link_start_ctrl.sv */
`timescale 1ns/1ps

module link_start_ctrl #(
   parameter link_cfg_pkg::rate_t LOCAL_RATE = link_cfg_pkg::RATE_FULL
) (
   input  logic                      m_wr_clk,
   input  logic                      m_wr_rst_n,
   input  lane_fmt_pkg::lane_en_t    i_sl_en,
   input  lane_fmt_pkg::lane_en_t    i_ms_en,
   input  link_cfg_pkg::delay_raw_t  i_delay_x,
   output logic                      o_sl_tx_transfer_en,
   output logic                      o_ms_tx_transfer_en,
   output logic                      o_link_ready
);
   import link_cfg_pkg::*;

   typedef enum logic [1:0] {ST_IDLE, ST_SYNC, ST_LOAD, ST_COUNT} start_state_t;

   start_state_t state;
   delay_t       dly_meta;
   delay_t       dly_sync;
   delay_t       dly_scaled;
   delay_t       dly_cnt;
   logic         all_en;

   // ----------------------------------------
   // Transfer enables, P2P form
   // ----------------------------------------
   assign o_sl_tx_transfer_en = &i_sl_en;
   assign o_ms_tx_transfer_en = &i_ms_en;
   assign all_en              = o_sl_tx_transfer_en & o_ms_tx_transfer_en;

   // Delay is quasi-static, two flops are enough
   always_ff @(posedge m_wr_clk)
   begin
      dly_meta <= delay_t'(i_delay_x);              // Low 16 bits only
      dly_sync <= dly_meta;
   end

   assign dly_scaled = dly_sync / LOCAL_RATE;       // Delay in local clock cycles

   // ----------------------------------------
   // Start countdown
   // ----------------------------------------
   always_ff @(posedge m_wr_clk)
   begin
      if (!m_wr_rst_n)
      begin
         state   <= ST_IDLE;
         dly_cnt <= '0;
      end
      else if (!all_en)
      begin
         state <= ST_IDLE;                          // Any lane drop restarts the wait
      end
      else
      begin
         case (state)
            ST_IDLE:  state <= ST_SYNC;
            ST_SYNC:  state <= ST_LOAD;             // Let the synchronizer settle
            ST_LOAD:
            begin
               dly_cnt <= dly_scaled;
               state   <= ST_COUNT;
            end
            ST_COUNT:
            begin
               if (dly_cnt != '0)
                  dly_cnt <= dly_cnt - 1'b1;        // Holds at zero once expired
            end
         endcase
      end
   end

   assign o_link_ready = (state == ST_COUNT) && (dly_cnt == '0);

   // A dropped enable closes the link on the very next edge
   a_ready_needs_en : assert property (@(posedge m_wr_clk) disable iff (!m_wr_rst_n)
      !all_en |=> !o_link_ready);

endmodule

/* rtl/marker_gen.sv */
`timescale 1ns/1ps

module marker_gen #(
   parameter link_cfg_pkg::rate_t LOCAL_RATE  = link_cfg_pkg::RATE_FULL,
   parameter link_cfg_pkg::rate_t REMOTE_RATE = link_cfg_pkg::RATE_HALF
) (
   input  logic m_wr_clk,
   input  logic m_wr_rst_n,
   input  logic i_push,
   output logic o_marker
);
   import link_cfg_pkg::*;

   localparam rate_t PERIOD   = REMOTE_RATE / LOCAL_RATE;  // Local words per remote word
   localparam rate_t MRK_LAST = PERIOD - 1'b1;

   rate_t mrk_cnt;

   // ----------------------------------------
   // Position inside the remote word
   // ----------------------------------------
   always_ff @(posedge m_wr_clk)
   begin
      if (!m_wr_rst_n)
      begin
         mrk_cnt <= '0;
      end
      else if (i_push)
      begin
         if (mrk_cnt == MRK_LAST)
            mrk_cnt <= '0;                          // Remote word complete
         else
            mrk_cnt <= mrk_cnt + 1'b1;
      end
   end

   assign o_marker = (mrk_cnt == MRK_LAST);         // Last local word of the group

   a_cnt_in_period : assert property (@(posedge m_wr_clk) disable iff (!m_wr_rst_n)
      mrk_cnt < PERIOD);

endmodule

/* rtl/strobe_gen.sv */
`timescale 1ns/1ps

module strobe_gen (
   input  logic m_wr_clk,
   input  logic m_wr_rst_n,
   input  logic i_push,
   input  logic i_marker,
   output logic o_strobe
);
   import link_cfg_pkg::*;

   localparam int                CNT_W    = $clog2(STROBE_INTV);
   localparam logic [CNT_W-1:0]  STB_LAST = CNT_W'(STROBE_INTV - 1);

   logic [CNT_W-1:0] stb_cnt;
   logic             mrk_push;

   assign mrk_push = i_push & i_marker;             // Only remote words advance the count

   // ----------------------------------------
   // Marked word counter
   // ----------------------------------------
   always_ff @(posedge m_wr_clk)
   begin
      if (!m_wr_rst_n)
      begin
         stb_cnt <= '0;
      end
      else if (mrk_push)
      begin
         if (stb_cnt == STB_LAST)
            stb_cnt <= '0;                          // Wrap after the strobe word
         else
            stb_cnt <= stb_cnt + 1'b1;
      end
   end

   // Strobe rides on the marked word that closes the interval
   assign o_strobe = i_marker && (stb_cnt == STB_LAST);

   // A sent strobe always sits on a marker and restarts the interval
   a_strobe_on_marker : assert property (@(posedge m_wr_clk) disable iff (!m_wr_rst_n)
      (i_push && o_strobe) |-> i_marker ##1 (stb_cnt == '0));

endmodule

/* rtl/lane_packer.sv */
`timescale 1ns/1ps

module lane_packer (
   input  logic                     m_wr_clk,
   input  logic                     m_wr_rst_n,
   input  link_cfg_pkg::tdata_t     i_tdata,
   input  logic                     i_tvalid,
   input  logic                     i_link_ready,
   input  logic                     i_marker,
   input  logic                     i_strobe,
   output logic                     o_push,
   output lane_fmt_pkg::lane_bus_t  o_lanes
);
   import lane_fmt_pkg::*;

   localparam int PAY_BITS = NUM_LANES * DATA_BITS_PER_LANE;  // 259 payload slots
   localparam int PAD_BITS = PAY_BITS - $bits(i_tdata);

   logic [PAY_BITS-1:0] data_ext;
   lane_bus_t           lanes_nxt;
   lane_bus_t           lanes_q;
   logic                accept;

   // ----------------------------------------
   // Handshake
   // ----------------------------------------
   assign accept = i_tvalid & i_link_ready;
   assign o_push = accept;                          // One pulse per accepted word

   assign data_ext = {{PAD_BITS{1'b0}}, i_tdata};   // Top of lane 6 stays zero

   // ----------------------------------------
   // Lane word build
   // ----------------------------------------
   for (genvar n = 0; n < NUM_LANES; n++)
   begin : g_lane
      lane_word_t lane_w;

      assign lane_w[PUSH_BIT] = 1'b1;
      assign lane_w[STB_BIT]  = i_strobe;
      assign lane_w[MRK_BIT]  = i_marker;           // Same marker on every lane
      assign lane_w[DATA_LO +: DATA_BITS_PER_LANE] =
         data_ext[n*DATA_BITS_PER_LANE +: DATA_BITS_PER_LANE];

      assign lanes_nxt[n*LANE_BITS +: LANE_BITS] = lane_w;
   end

   // ----------------------------------------
   // Output register
   // ----------------------------------------
   always_ff @(posedge m_wr_clk)
   begin
      if (!m_wr_rst_n)
      begin
         lanes_q <= '0;
      end
      else if (accept)
      begin
         lanes_q <= lanes_nxt;
      end
      else
      begin
         lanes_q <= '0;                             // Idle cycle, push bits low
      end
   end

   assign o_lanes = lanes_q;

endmodule

/* rtl/leader_tx_top.sv */
`timescale 1ns/1ps

module leader_tx_top #(
   parameter link_cfg_pkg::rate_t LOCAL_RATE  = link_cfg_pkg::RATE_FULL,
   parameter link_cfg_pkg::rate_t REMOTE_RATE = link_cfg_pkg::RATE_HALF
) (
   input  logic                      m_wr_clk,
   input  logic                      m_wr_rst_n,
   input  link_cfg_pkg::tdata_t      i_tx_tdata,
   input  logic                      i_tx_tvalid,
   output logic                      o_tx_tready,
   input  lane_fmt_pkg::lane_en_t    i_tx_sl_en,
   input  lane_fmt_pkg::lane_en_t    i_tx_ms_en,
   input  link_cfg_pkg::delay_raw_t  i_delay_x,
   output lane_fmt_pkg::lane_bus_t   o_ca2phy,
   output logic                      o_sl_tx_transfer_en,
   output logic                      o_ms_tx_transfer_en
);

   logic push;                                      // Accepted word this cycle
   logic marker;
   logic strobe;

   // ----------------------------------------
   // Link bring-up
   // ----------------------------------------
   link_start_ctrl #(
      .LOCAL_RATE           (LOCAL_RATE)
   ) u_link_start_ctrl (
      .m_wr_clk             (m_wr_clk),
      .m_wr_rst_n           (m_wr_rst_n),
      .i_sl_en              (i_tx_sl_en),
      .i_ms_en              (i_tx_ms_en),
      .i_delay_x            (i_delay_x),
      .o_sl_tx_transfer_en  (o_sl_tx_transfer_en),
      .o_ms_tx_transfer_en  (o_ms_tx_transfer_en),
      .o_link_ready         (o_tx_tready)            // Ready is the link-open level
   );

   // ----------------------------------------
   // Per-word control bits
   // ----------------------------------------
   marker_gen #(
      .LOCAL_RATE   (LOCAL_RATE),
      .REMOTE_RATE  (REMOTE_RATE)
   ) u_marker_gen (
      .m_wr_clk     (m_wr_clk),
      .m_wr_rst_n   (m_wr_rst_n),
      .i_push       (push),
      .o_marker     (marker)
   );

   strobe_gen u_strobe_gen (
      .m_wr_clk     (m_wr_clk),
      .m_wr_rst_n   (m_wr_rst_n),
      .i_push       (push),
      .i_marker     (marker),
      .o_strobe     (strobe)
   );

   lane_packer u_lane_packer (
      .m_wr_clk     (m_wr_clk),
      .m_wr_rst_n   (m_wr_rst_n),
      .i_tdata      (i_tx_tdata),
      .i_tvalid     (i_tx_tvalid),
      .i_link_ready (o_tx_tready),
      .i_marker     (marker),
      .i_strobe     (strobe),
      .o_push       (push),
      .o_lanes      (o_ca2phy)
   );

endmodule

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD_NS  = 40,
   parameter int RST_CYCLES = 4
) (
   output logic o_clk,
   output logic o_rst_n
);

   initial
   begin
      o_clk = 1'b0;
      forever #(PERIOD_NS / 2) o_clk = ~o_clk;
   end

   initial
   begin
      o_rst_n = 1'b0;
      #(PERIOD_NS * RST_CYCLES);                    // Release lands on a falling edge
      o_rst_n = 1'b1;
   end

endmodule

/* verification/tb_leader_tx.sv */
`timescale 1ns/1ps

module tb_leader_tx;
   import lane_fmt_pkg::*;
   import link_cfg_pkg::*;

   localparam int NUM_ROWS   = 7;
   localparam int MRK_PERIOD = 2;                   // Remote half rate over local full rate
   localparam int STB_PERIOD = 24;                  // Local words between strobes

   logic       m_wr_clk;
   logic       m_wr_rst_n;
   tdata_t     tx_tdata;
   logic       tx_tvalid;
   logic       tx_tready;
   lane_en_t   tx_sl_en;
   lane_en_t   tx_ms_en;
   delay_raw_t delay_x;
   lane_bus_t  ca2phy;
   logic       sl_transfer_en;
   logic       ms_transfer_en;

   // Stimulus table with one row per test
   string      row_name   [NUM_ROWS];
   delay_raw_t row_delay  [NUM_ROWS];
   lane_en_t   row_sl     [NUM_ROWS];
   lane_en_t   row_ms     [NUM_ROWS];
   logic       row_sl_on  [NUM_ROWS];               // Expected SL transfer enable
   logic       row_ms_on  [NUM_ROWS];               // Expected MS transfer enable
   int         row_cycles [NUM_ROWS];
   int         row_dens   [NUM_ROWS];               // Valid chance in eighths

   logic [31:0] lfsr_q = 32'he237ae37;
   int   cur_row, word_k, wait_edges, cycle_cnt, cycle_limit;
   logic acc_pending, ready_seen;
   int   lane_errs, ready_errs, en_errs, other_errs;

   tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(4)) u_clk_gen (
      .o_clk   (m_wr_clk),
      .o_rst_n (m_wr_rst_n)
   );

   leader_tx_top #(
      .LOCAL_RATE  (RATE_FULL),
      .REMOTE_RATE (RATE_HALF)
   ) dut (
      .m_wr_clk            (m_wr_clk),
      .m_wr_rst_n          (m_wr_rst_n),
      .i_tx_tdata          (tx_tdata),
      .i_tx_tvalid         (tx_tvalid),
      .o_tx_tready         (tx_tready),
      .i_tx_sl_en          (tx_sl_en),
      .i_tx_ms_en          (tx_ms_en),
      .i_delay_x           (delay_x),
      .o_ca2phy            (ca2phy),
      .o_sl_tx_transfer_en (sl_transfer_en),
      .o_ms_tx_transfer_en (ms_transfer_en)
   );

   // ----------------------------------------
   // Random bits and reference model
   // ----------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'hA300_0000;           // Galois form with taps 32 30 26 25
      return s >> 1;
   endfunction

   task automatic draw_bits(input int n, output tdata_t bits);
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
         bits[i] = lfsr_q[0];
         lfsr_q  = lfsr_next(lfsr_q);
      end
   endtask

   // Lane n carries user bits 37n upward with control bits at the lane edges
   function automatic lane_bus_t expected_lanes(input tdata_t data, input int k);
      lane_bus_t bus;
      int        src;
      bus = '0;
      for (int n = 0; n < NUM_LANES; n++)
      begin
         bus[n*LANE_BITS + PUSH_BIT] = 1'b1;
         bus[n*LANE_BITS + STB_BIT]  = (k % STB_PERIOD == STB_PERIOD - 1);
         bus[n*LANE_BITS + MRK_BIT]  = (k % MRK_PERIOD == MRK_PERIOD - 1);
         for (int b = 0; b < DATA_BITS_PER_LANE; b++)
         begin
            src = n*DATA_BITS_PER_LANE + b;
            if (src < $bits(tdata_t))
               bus[n*LANE_BITS + DATA_LO + b] = data[src];
         end
      end
      return bus;
   endfunction

   // ----------------------------------------
   // Compare tasks
   // ----------------------------------------
   task automatic check_lanes(input string tname, input lane_bus_t exp, input lane_bus_t act);
      if (act !== exp)
      begin
         lane_errs++;
         $display("ERROR %s: lanes expected %h actual %h", tname, exp, act);
      end
   endtask

   task automatic check_ready(input string tname, input logic exp, input logic act);
      if (act !== exp)
      begin
         ready_errs++;
         $display("ERROR %s: ready expected %b actual %b", tname, exp, act);
      end
   endtask

   task automatic check_en(input string tname, input logic exp, input logic act);
      if (act !== exp)
      begin
         en_errs++;
         $display("ERROR %s: transfer enable expected %b actual %b", tname, exp, act);
      end
   endtask

   task automatic set_row(input int idx, input string name, input delay_raw_t dly,
                          input lane_en_t sl, input lane_en_t ms, input logic sl_on,
                          input logic ms_on, input int cyc, input int dens);
      row_name[idx]   = name;
      row_delay[idx]  = dly;
      row_sl[idx]     = sl;
      row_ms[idx]     = ms;
      row_sl_on[idx]  = sl_on;
      row_ms_on[idx]  = ms_on;
      row_cycles[idx] = cyc;
      row_dens[idx]   = dens;
   endtask

   task automatic load_table();
      int total;
      set_row(0, "all_off",   32'hABCD_0008, 7'h00, 7'h00, 1'b0, 1'b0,  20, 8);
      set_row(1, "part_en",   32'hABCD_0008, 7'h7F, 7'h3F, 1'b1, 1'b0,  20, 8);
      set_row(2, "open_full", 32'hABCD_0008, 7'h7F, 7'h7F, 1'b1, 1'b1, 120, 8);
      set_row(3, "sparse",    32'hABCD_0008, 7'h7F, 7'h7F, 1'b1, 1'b1,  80, 3);
      set_row(4, "drop_en",   32'hABCD_0008, 7'h7E, 7'h7F, 1'b0, 1'b1,  10, 8);
      set_row(5, "reopen",    32'h1234_0014, 7'h7F, 7'h7F, 1'b1, 1'b1, 150, 5);
      set_row(6, "long_run",  32'h1234_0014, 7'h7F, 7'h7F, 1'b1, 1'b1, 300, 7);
      total = 0;
      for (int r = 0; r < NUM_ROWS; r++)
         total += row_cycles[r];
      cycle_limit = total + 200;
   endtask

   // Checks what the DUT made of the inputs driven one cycle earlier
   task automatic check_cycle();
      logic all_prev;
      int   d;
      all_prev = row_sl_on[cur_row] & row_ms_on[cur_row];
      d        = int'(row_delay[cur_row][15:0]);    // Local rate is full
      check_en(row_name[cur_row], row_sl_on[cur_row], sl_transfer_en);
      check_en(row_name[cur_row], row_ms_on[cur_row], ms_transfer_en);
      if (all_prev)
         wait_edges++;
      else
         wait_edges = 0;
      if (!all_prev)
         check_ready(row_name[cur_row], 1'b0, tx_tready);
      else if (ready_seen)
         check_ready(row_name[cur_row], 1'b1, tx_tready);
      else if (tx_tready && (wait_edges < d || wait_edges > d + 4))
      begin
         other_errs++;
         $display("Ready opened after %0d cycles in %s, outside the window %0d to %0d",
                  wait_edges, row_name[cur_row], d, d + 4);
      end
      else if (!tx_tready && wait_edges == d + 5)
      begin
         other_errs++;
         $display("Ready still closed %0d cycles after all enables rose in %s",
                  wait_edges, row_name[cur_row]);
      end
      if (acc_pending)
      begin
         check_lanes(row_name[cur_row], expected_lanes(tx_tdata, word_k), ca2phy);
         word_k++;
      end
      else
         check_lanes(row_name[cur_row], '0, ca2phy);
      ready_seen = tx_tready;
   endtask

   task automatic drive_cycle(input int r);
      tdata_t rnd;
      logic   hold;
      hold     = tx_tvalid && !acc_pending;          // Refused word stays on the bus
      cur_row  = r;
      delay_x  = row_delay[r];
      tx_sl_en = row_sl[r];
      tx_ms_en = row_ms[r];
      if (!hold)
      begin
         draw_bits(3, rnd);
         tx_tvalid = (int'(rnd[2:0]) < row_dens[r]);
         if (tx_tvalid)
         begin
            draw_bits(256, rnd);
            tx_tdata = rnd;
         end
      end
      acc_pending = tx_tvalid && tx_tready;         // Ready only moves on a rising edge
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial
   begin
      int total;
      tx_tdata    = '0;
      tx_tvalid   = 1'b0;
      tx_sl_en    = '0;
      tx_ms_en    = '0;
      delay_x     = '0;
      cur_row     = 0;
      word_k      = 0;
      wait_edges  = 0;
      acc_pending = 1'b0;
      ready_seen  = 1'b0;
      load_table();
      wait (m_wr_rst_n === 1'b1);
      @(posedge m_wr_clk);
      @(negedge m_wr_clk);
      check_ready("reset", 1'b0, tx_tready);
      check_lanes("reset", '0, ca2phy);
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         for (int c = 0; c < row_cycles[r]; c++)
         begin
            check_cycle();
            drive_cycle(r);
            @(negedge m_wr_clk);
         end
      end
      check_cycle();
      total = lane_errs + ready_errs + en_errs + other_errs;
      $display("Words %0d, errors: lanes %0d ready %0d enable %0d other %0d",
               word_k, lane_errs, ready_errs, en_errs, other_errs);
      if (total == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   // Watchdog
   initial
   begin
      cycle_cnt = 0;
      wait (cycle_limit > 0);
      while (cycle_cnt < cycle_limit)
      begin
         @(posedge m_wr_clk);
         cycle_cnt++;
      end
      $display("Timeout, the test loop did not end within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

/* sim.f */
rtl/lane_fmt_pkg.sv
rtl/link_cfg_pkg.sv
rtl/link_start_ctrl.sv
rtl/marker_gen.sv
rtl/strobe_gen.sv
rtl/lane_packer.sv
rtl/leader_tx_top.sv
verification/tb_clk_gen.sv
verification/tb_leader_tx.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_leader_tx -f sim.f -o tb_leader_tx > build.log 2>&1 \
   && ./obj_dir/tb_leader_tx > sim.log 2>&1

grep -q "Simulation finished: PASS" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
